// ==== sim.f ====
+incdir+testbench
logic/lsu_pmp_pkg.sv
logic/pmp_cfg_regs.sv
logic/pmp_checker.sv
logic/lsu_data_align.sv
logic/lsu_bus_ctrl.sv
logic/lsu_pmp_top.sv
testbench/tb_lsu_pmp.sv

// ==== testbench/tb_lsu_pmp_model.svh ====
//////////////////////////////////////////////////
// Reference model, included inside tb_lsu_pmp.
// Needs MEM_WORDS and WORD_BITS from the includer
//////////////////////////////////////////////////

`ifndef TB_LSU_PMP_MODEL_SVH
`define TB_LSU_PMP_MODEL_SVH

pmp_entry_t        exp_entries [NUM_REGIONS];
priv_lvl_e         exp_priv;
logic [DATA_W-1:0] ref_mem [MEM_WORDS];

// Every word differs, so a wrong index shows up
function automatic logic [DATA_W-1:0] fill_word(input int idx);
  logic [7:0] i8;
  i8 = idx[7:0];
  return {i8 ^ 8'h3C, ~i8, i8 + 8'h11, i8};
endfunction

function automatic void reset_model();
  exp_priv = PRIV_M;
  for (int i = 0; i < NUM_REGIONS; i++) begin
    exp_entries[i] = '0;
  end
endfunction

// Word 0 privilege, then configs, then region addresses
function automatic void write_reg_model(input int adr, input logic [DATA_W-1:0] dat);
  if (adr == 0) begin
    exp_priv = priv_lvl_e'(dat[0]);
  end else if (adr >= 1 && adr <= NUM_REGIONS) begin
    if (!exp_entries[adr-1].cfg.lock) begin
      exp_entries[adr-1].cfg = pmp_cfg_t'(dat[4:0]);
    end
  end else if (adr > NUM_REGIONS && adr <= 2 * NUM_REGIONS) begin
    if (!exp_entries[adr-NUM_REGIONS-1].cfg.lock) begin
      exp_entries[adr-NUM_REGIONS-1].addr = dat[29:0];
    end
  end
endfunction

function automatic logic [DATA_W-1:0] read_reg_model(input int adr);
  logic [DATA_W-1:0] w;
  w = '0;
  if (adr == 0) begin
    w[0] = exp_priv;
  end else if (adr <= NUM_REGIONS) begin
    w[4:0] = exp_entries[adr-1].cfg;
  end else if (adr <= 2 * NUM_REGIONS) begin
    w[29:0] = exp_entries[adr-NUM_REGIONS-1].addr;
  end
  return w;
endfunction

function automatic logic [BE_W-1:0] lane_enables(input mem_type_e t, input logic [1:0] off);
  case (t)
    MEM_BYTE: return BE_W'(1) << off;
    MEM_HALF: return BE_W'(3) << off;
    default:  return '1;
  endcase
endfunction

function automatic logic [DATA_W-1:0] place_lanes(input logic [DATA_W-1:0] d,
                                                  input logic [1:0] off);
  return d << (8 * off);
endfunction

function automatic logic is_misaligned(input mem_type_e t, input logic [1:0] off);
  if (t == MEM_WORD) begin
    return off != 2'b00;
  end
  return (t == MEM_HALF) && off[0];
endfunction

function automatic logic [DATA_W-1:0] load_value(input logic [ADDR_W-1:0] addr,
                                                 input mem_type_e t, input logic sext);
  logic [DATA_W-1:0] word;
  logic [15:0]       half;
  logic [7:0]        byte_v;
  word = ref_mem[addr[WORD_BITS+1:2]];
  case (t)
    MEM_BYTE: begin
      byte_v = word[8*addr[1:0] +: 8];
      return sext ? {{24{byte_v[7]}}, byte_v} : {24'd0, byte_v};
    end
    MEM_HALF: begin
      half = word[16*addr[1] +: 16];
      return sext ? {{16{half[15]}}, half} : {16'd0, half};
    end
    default: return word;
  endcase
endfunction

function automatic void store_to_model(input logic [ADDR_W-1:0] addr, input mem_type_e t,
                                       input logic [DATA_W-1:0] data);
  logic [BE_W-1:0]   be;
  logic [DATA_W-1:0] lanes;
  int                idx;
  be    = lane_enables(t, addr[1:0]);
  lanes = place_lanes(data, addr[1:0]);
  idx   = addr[WORD_BITS+1:2];
  for (int b = 0; b < BE_W; b++) begin
    if (be[b]) begin
      ref_mem[idx][8*b +: 8] = lanes[8*b +: 8];
    end
  end
endfunction

// First matching entry decides, none matching leaves only M mode through
function automatic logic pmp_permits(input logic [ADDR_W-1:0] addr, input logic we);
  logic [29:0] wa;
  logic [29:0] lo;
  logic        hit;
  logic        perm;
  wa = addr[31:2];
  for (int i = 0; i < NUM_REGIONS; i++) begin
    lo = (i == 0) ? 30'd0 : exp_entries[i-1].addr;
    case (exp_entries[i].cfg.mode)
      PMP_TOR: hit = (wa >= lo) && (wa < exp_entries[i].addr);
      PMP_NA4: hit = (wa == exp_entries[i].addr);
      default: hit = 1'b0;
    endcase
    if (hit) begin
      perm = we ? exp_entries[i].cfg.w : exp_entries[i].cfg.r;
      if (exp_priv == PRIV_M) begin
        return perm || !exp_entries[i].cfg.lock;
      end
      return perm;
    end
  end
  return exp_priv == PRIV_M;
endfunction

`endif

// ==== testbench/tb_lsu_pmp.sv ====
//////////////////////////////////////////////////
// Random testbench for the load/store unit. Memory
// responder holds 256 words and commands stay inside
//////////////////////////////////////////////////

`default_nettype none

module tb_lsu_pmp import lsu_pmp_pkg::*; ();

  localparam int unsigned SEED = 32'h3548_7215;
  localparam int MEM_WORDS   = 256;
  localparam int WORD_BITS   = 8;
  localparam int N_LOADS     = 64;
  localparam int N_STORES    = 32;
  localparam int N_ROUNDS    = 16;
  localparam int N_PMP_CMDS  = 8;
  localparam int N_MISALIGN  = 16;
  localparam int N_ERR_LOADS = 32;
  localparam int N_OPS = 128 + N_LOADS + 2 * N_STORES
                       + N_ROUNDS * (2 * NUM_REGIONS + 1 + N_PMP_CMDS)
                       + N_MISALIGN + N_ERR_LOADS;
  localparam int WATCHDOG_CYCLES = 200 * N_OPS;

  logic              clk;
  logic              rst_n;
  logic              cmd_valid;
  lsu_cmd_t          cmd;
  logic              cmd_ready;
  logic              rsp_valid;
  lsu_rsp_t          rsp;
  mem_req_t          mem_req;
  logic              mem_gnt    = 1'b0;
  logic              mem_rvalid = 1'b0;
  logic              mem_err    = 1'b0;
  logic [DATA_W-1:0] mem_rdata  = '0;
  wb_req_t           wb_req;
  logic              wb_ack;
  logic [DATA_W-1:0] wb_dat;

  // Responder state
  logic              req_seen   = 1'b0;
  logic              pend_err   = 1'b0;
  logic              inject_err = 1'b0;
  int                gnt_wait   = 0;
  int                rv_cnt     = 0;
  int                pend_idx   = 0;
  logic [DATA_W-1:0] bus_mem [MEM_WORDS];

  int          rsp_errs   = 0;
  int          mem_errs   = 0;
  int          wb_errs    = 0;
  int          proto_errs = 0;
  int unsigned seed_val;
  logic [ADDR_W-1:0] stored_q [$];

  `include "tb_lsu_pmp_model.svh"

  lsu_pmp_top lsu_pmp_top_inst (
    .clk          (clk),
    .rst_ni       (rst_n),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .cmd_ready_o  (cmd_ready),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp),
    .mem_o        (mem_req),
    .mem_gnt_i    (mem_gnt),
    .mem_rvalid_i (mem_rvalid),
    .mem_err_i    (mem_err),
    .mem_rdata_i  (mem_rdata),
    .wb_i         (wb_req),
    .wb_ack_o     (wb_ack),
    .wb_dat_o     (wb_dat)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped answering", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Memory responder
  //////////////////////////////////////////////////

  always @(posedge clk) begin : responder
    logic err_now;
    mem_rvalid <= 1'b0;
    mem_err    <= 1'b0;
    if (mem_req.req && mem_gnt) begin
      err_now = inject_err && ($urandom_range(0, 1) == 1);
      mem_gnt  <= 1'b0;
      req_seen <= 1'b0;
      pend_err <= err_now;
      pend_idx <= mem_req.addr[WORD_BITS+1:2];
      rv_cnt   <= $urandom_range(1, 3);
      // Faulted stores leave memory alone
      if (mem_req.we && !err_now) begin
        for (int b = 0; b < BE_W; b++) begin
          if (mem_req.be[b]) begin
            bus_mem[mem_req.addr[WORD_BITS+1:2]][8*b +: 8] = mem_req.wdata[8*b +: 8];
          end
        end
      end
    end else if (mem_req.req) begin
      if (!req_seen) begin
        req_seen <= 1'b1;
        gnt_wait <= $urandom_range(0, 3);
      end else if (gnt_wait == 0) begin
        mem_gnt <= 1'b1;
      end else begin
        gnt_wait <= gnt_wait - 1;
      end
    end
    if (rv_cnt == 1) begin
      mem_rvalid <= 1'b1;
      mem_err    <= pend_err;
      mem_rdata  <= bus_mem[pend_idx];
    end
    if (rv_cnt != 0) begin
      rv_cnt <= rv_cnt - 1;
    end
  end

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic check_rsp(input string name, input lsu_rsp_t got, input lsu_rsp_t exp);
    if (got !== exp) begin
      rsp_errs++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_mem(input string name, input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      mem_errs++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_wb(input string name, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      wb_errs++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    reset_model();
    @(negedge clk);
    if (!cmd_ready || mem_req.req || rsp_valid || wb_ack) begin
      proto_errs++;
      $display("Outputs after reset are not idle");
    end
  endtask

  task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
                           input logic [DATA_W-1:0] dat, output logic [DATA_W-1:0] rdat);
    wb_req_t w;
    w.cyc = 1'b1;
    w.stb = 1'b1;
    w.we  = we;
    w.adr = adr;
    w.dat = dat;
    @(posedge clk);
    wb_req <= w;
    @(negedge clk);
    while (!wb_ack) @(negedge clk);
    rdat = wb_dat;
    @(posedge clk);
    wb_req <= '0;
  endtask

  task automatic wb_write(input int adr, input logic [DATA_W-1:0] dat);
    logic [DATA_W-1:0] unused;
    wb_access(1'b1, WB_AW'(adr), dat, unused);
    write_reg_model(adr, dat);
  endtask

  task automatic wb_read_check(input int adr);
    logic [DATA_W-1:0] rdat;
    wb_access(1'b0, WB_AW'(adr), '0, rdat);
    check_wb("wb_dat_o", rdat, read_reg_model(adr));
  endtask

  // One command end to end, checked against the model
  task automatic run_cmd_checked(input lsu_cmd_t c);
    lsu_rsp_t   exp_rsp;
    mem_req_t   exp_req;
    mem_req_t   got_req;
    logic       want_req;
    logic       saw_req;
    logic       saw_ready;
    logic [1:0] off;
    off           = c.addr[1:0];
    exp_req.req   = 1'b1;
    exp_req.we    = c.we;
    exp_req.be    = lane_enables(c.mtype, off);
    exp_req.addr  = {c.addr[31:2], 2'b00};
    exp_req.wdata = place_lanes(c.wdata, off);
    exp_rsp.rdata = '0;
    want_req      = 1'b0;
    if (is_misaligned(c.mtype, off)) begin
      exp_rsp.err = ERR_MISALIGNED;
    end else if (!pmp_permits(c.addr, c.we)) begin
      exp_rsp.err = ERR_PMP;
    end else begin
      want_req    = 1'b1;
      exp_rsp.err = ERR_NONE;
      if (!c.we) begin
        exp_rsp.rdata = load_value(c.addr, c.mtype, c.sign_ext);
      end
    end
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    @(posedge clk);
    cmd_valid <= 1'b0;
    @(negedge clk);
    if (rsp_valid == mem_req.req) begin
      proto_errs++;
      $display("Command to %h was not answered by exactly one of response or request", c.addr);
    end
    saw_req   = 1'b0;
    saw_ready = 1'b0;
    got_req   = '0;
    while (!rsp_valid) begin
      saw_ready = saw_ready | cmd_ready;
      if (mem_req.req && !saw_req) begin
        saw_req = 1'b1;
        got_req = mem_req;
      end
      @(negedge clk);
    end
    saw_ready = saw_ready | cmd_ready;
    if (saw_ready) begin
      proto_errs++;
      $display("Ready was high while the command to %h was in flight", c.addr);
    end
    if (want_req != saw_req) begin
      proto_errs++;
      $display("Command to %h: request expected %0d but seen %0d", c.addr, want_req, saw_req);
    end else if (want_req) begin
      check_mem("mem_o", got_req, exp_req);
      if (pend_err) begin
        exp_rsp.rdata = '0;
        exp_rsp.err   = ERR_BUS;
      end else if (c.we) begin
        store_to_model(c.addr, c.mtype, c.wdata);
      end
    end
    check_rsp("rsp_o", rsp, exp_rsp);
    @(negedge clk);
    if (rsp_valid || !cmd_ready) begin
      proto_errs++;
      $display("Unit did not return to idle one cycle after answering %h", c.addr);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic lsu_cmd_t align_cmd(input lsu_cmd_t c);
    if (c.mtype == MEM_WORD) begin
      c.addr[1:0] = 2'b00;
    end else if (c.mtype == MEM_HALF) begin
      c.addr[0] = 1'b0;
    end
    return c;
  endfunction

  function automatic lsu_cmd_t rand_cmd(input logic we);
    lsu_cmd_t c;
    c.we       = we;
    c.mtype    = mem_type_e'($urandom_range(0, 2));
    c.sign_ext = $urandom_range(0, 1);
    c.addr     = $urandom_range(0, MEM_WORDS * 4 - 1);
    c.wdata    = $urandom;
    return align_cmd(c);
  endfunction

  function automatic lsu_cmd_t misaligned_cmd();
    lsu_cmd_t c;
    c = rand_cmd($urandom_range(0, 1));
    if (c.mtype == MEM_BYTE) begin
      c.mtype = MEM_HALF;
    end
    if (c.mtype == MEM_HALF) begin
      c.addr[0] = 1'b1;
    end else begin
      c.addr[1:0] = 2'($urandom_range(1, 3));
    end
    return c;
  endfunction

  function automatic pmp_cfg_t rand_cfg();
    pmp_cfg_t c;
    c.r    = $urandom_range(0, 1);
    c.w    = $urandom_range(0, 1);
    c.lock = ($urandom_range(0, 7) == 0);
    case ($urandom_range(0, 2))
      0:       c.mode = PMP_OFF;
      1:       c.mode = PMP_TOR;
      default: c.mode = PMP_NA4;
    endcase
    return c;
  endfunction

  // Half the probes land on an entry address so NA4 gets hits
  function automatic lsu_cmd_t pmp_probe_cmd();
    lsu_cmd_t c;
    int       k;
    c = rand_cmd($urandom_range(0, 1));
    if ($urandom_range(0, 1) == 1) begin
      k = $urandom_range(0, NUM_REGIONS - 1);
      c.addr = {exp_entries[k].addr, 2'b00} + $urandom_range(0, 3);
    end
    return align_cmd(c);
  endfunction

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    lsu_cmd_t c;
    int       total;
    seed_val  = $urandom(SEED);
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    wb_req    = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(i);
      bus_mem[i] = fill_word(i);
    end
    apply_reset();

    // Register map, lock and unmapped words
    for (int pass = 0; pass < 2; pass++) begin
      for (int a = 0; a < 32; a++) begin
        wb_write(a, $urandom);
        wb_read_check(a);
      end
    end
    apply_reset();

    // Loads, M mode, no entries
    for (int k = 0; k < N_LOADS; k++) begin
      run_cmd_checked(rand_cmd(1'b0));
    end

    // Stores then word loads over the same words
    for (int k = 0; k < N_STORES; k++) begin
      c = rand_cmd(1'b1);
      stored_q.push_back(c.addr);
      run_cmd_checked(c);
    end
    foreach (stored_q[k]) begin
      c          = rand_cmd(1'b0);
      c.mtype    = MEM_WORD;
      c.sign_ext = 1'b0;
      c.addr     = {stored_q[k][31:2], 2'b00};
      run_cmd_checked(c);
    end

    // Random PMP setups in both modes
    for (int r = 0; r < N_ROUNDS; r++) begin
      for (int i = 0; i < NUM_REGIONS; i++) begin
        wb_write(1 + i, {27'd0, rand_cfg()});
        wb_write(1 + NUM_REGIONS + i, $urandom_range(0, MEM_WORDS - 1));
      end
      wb_write(0, $urandom_range(0, 1));
      for (int k = 0; k < N_PMP_CMDS; k++) begin
        run_cmd_checked(pmp_probe_cmd());
      end
    end
    apply_reset();

    // Misaligned rejects, then loads with bus faults
    for (int k = 0; k < N_MISALIGN; k++) begin
      run_cmd_checked(misaligned_cmd());
    end
    inject_err = 1'b1;
    for (int k = 0; k < N_ERR_LOADS; k++) begin
      run_cmd_checked(rand_cmd(1'b0));
    end
    inject_err = 1'b0;

    total = rsp_errs + mem_errs + wb_errs + proto_errs;
    $display("Error counts: rsp %0d, mem %0d, wb %0d, protocol %0d",
             rsp_errs, mem_errs, wb_errs, proto_errs);
    if (total == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/lsu_pmp_top.sv ====
//////////////////////////////////////////////////
// Load/store unit with data side PMP. Config is
// only written while no command is in flight
//////////////////////////////////////////////////

`default_nettype none

module lsu_pmp_top import lsu_pmp_pkg::*; (
  input  logic              clk,
  input  logic              rst_ni,
  input  logic              cmd_valid_i,
  input  lsu_cmd_t          cmd_i,
  output logic              cmd_ready_o,
  output logic              rsp_valid_o,
  output lsu_rsp_t          rsp_o,
  output mem_req_t          mem_o,
  input  logic              mem_gnt_i,
  input  logic              mem_rvalid_i,
  input  logic              mem_err_i,
  input  logic [DATA_W-1:0] mem_rdata_i,
  input  wb_req_t           wb_i,
  output logic              wb_ack_o,
  output logic [DATA_W-1:0] wb_dat_o
);

  pmp_entry_t        entries [NUM_REGIONS];
  priv_lvl_e         priv;
  lsu_cmd_t          cmd_q;
  logic              allow;
  logic              misaligned;
  logic [BE_W-1:0]   be;
  logic [DATA_W-1:0] wdata_lane;
  logic [DATA_W-1:0] rdata_ext;

  pmp_cfg_regs pmp_cfg_regs_inst (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .wb_i      (wb_i),
    .wb_ack_o  (wb_ack_o),
    .wb_dat_o  (wb_dat_o),
    .entries_o (entries),
    .priv_o    (priv)
  );

  pmp_checker pmp_checker_inst (
    .entries_i (entries),
    .priv_i    (priv),
    .addr_i    (cmd_q.addr),
    .we_i      (cmd_q.we),
    .allow_o   (allow)
  );

  lsu_data_align lsu_data_align_inst (
    .type_i       (cmd_q.mtype),
    .offset_i     (cmd_q.addr[1:0]),
    .sign_ext_i   (cmd_q.sign_ext),
    .wdata_i      (cmd_q.wdata),
    .rdata_i      (mem_rdata_i),
    .be_o         (be),
    .wdata_o      (wdata_lane),
    .rdata_o      (rdata_ext),
    .misaligned_o (misaligned)
  );

  lsu_bus_ctrl lsu_bus_ctrl_inst (
    .clk          (clk),
    .rst_ni       (rst_ni),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .cmd_ready_o  (cmd_ready_o),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_o        (rsp_o),
    .mem_o        (mem_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_err_i    (mem_err_i),
    .mem_rdata_i  (mem_rdata_i),
    .allow_i      (allow),
    .misaligned_i (misaligned),
    .cmd_q_o      (cmd_q),
    .be_i         (be),
    .wdata_i      (wdata_lane),
    .rdata_i      (rdata_ext)
  );

endmodule

`default_nettype wire

// ==== logic/lsu_bus_ctrl.sv ====
//////////////////////////////////////////////////
// One command at a time; no back-pressure on the
// response. Memory side is req/gnt/rvalid with a
// single outstanding transaction
//////////////////////////////////////////////////

`default_nettype none

module lsu_bus_ctrl import lsu_pmp_pkg::*; (
  input  logic              clk,
  input  logic              rst_ni,
  input  logic              cmd_valid_i,
  input  lsu_cmd_t          cmd_i,
  output logic              cmd_ready_o,
  output logic              rsp_valid_o,
  output lsu_rsp_t          rsp_o,
  output mem_req_t          mem_o,
  input  logic              mem_gnt_i,
  input  logic              mem_rvalid_i,
  input  logic              mem_err_i,
  input  logic [DATA_W-1:0] mem_rdata_i,
  input  logic              allow_i,
  input  logic              misaligned_i,
  output lsu_cmd_t          cmd_q_o,
  input  logic [BE_W-1:0]   be_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [DATA_W-1:0] rdata_i
);

  typedef enum logic [2:0] {
    IDLE, ISSUE, WAIT_GNT, WAIT_RVALID, RESPOND
  } state_e;

  state_e            state_q, state_d;
  lsu_cmd_t          cmd_q;
  lsu_err_e          err_q;
  logic [DATA_W-1:0] rdata_q;
  logic              accept;
  logic              pass;
  logic              req;

  assign cmd_ready_o = (state_q == IDLE);
  assign accept      = cmd_valid_i & cmd_ready_o;
  assign pass        = allow_i & ~misaligned_i;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    req     = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (cmd_valid_i) begin
          state_d = ISSUE;
        end
      end
      // Checks settle here on the registered command
      ISSUE: begin
        if (!pass) begin
          state_d = IDLE;
        end else begin
          req     = 1'b1;
          state_d = mem_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        req = 1'b1;
        if (mem_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (mem_rvalid_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_i;
    end
    // Stores and faulted loads hand back zero
    if (state_q == WAIT_RVALID && mem_rvalid_i) begin
      err_q   <= mem_err_i ? ERR_BUS : ERR_NONE;
      rdata_q <= (mem_err_i || cmd_q.we) ? '0 : rdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  always_comb begin
    mem_o.req   = req;
    mem_o.we    = cmd_q.we;
    mem_o.be    = be_i;
    mem_o.addr  = {cmd_q.addr[ADDR_W-1:2], 2'b00};
    mem_o.wdata = wdata_i;
  end

  // Early rejects answer straight from ISSUE
  always_comb begin
    if (state_q == ISSUE) begin
      rsp_o.rdata = '0;
      rsp_o.err   = misaligned_i ? ERR_MISALIGNED : ERR_PMP;
    end else begin
      rsp_o.rdata = rdata_q;
      rsp_o.err   = err_q;
    end
  end

  assign rsp_valid_o = ((state_q == ISSUE) && !pass) || (state_q == RESPOND);
  assign cmd_q_o     = cmd_q;

  req_stable_a: assert property (@(posedge clk) disable iff (!rst_ni)
    (mem_o.req && !mem_gnt_i) |=> (mem_o.req && $stable(mem_o)));

  rvalid_after_gnt_a: assert property (@(posedge clk) disable iff (!rst_ni)
    mem_rvalid_i |-> (state_q == WAIT_RVALID));

  // Ready stays low from acceptance until the response has gone out
  ready_only_idle_a: assert property (@(posedge clk) disable iff (!rst_ni)
    (accept || (!cmd_ready_o && !rsp_valid_o)) |=> !cmd_ready_o);

  // Memory must hand back defined data on a clean read
  rdata_known_a: assert property (@(posedge clk) disable iff (!rst_ni)
    (mem_rvalid_i && !mem_err_i && !cmd_q.we) |-> !$isunknown(mem_rdata_i));

endmodule

`default_nettype wire

// ==== logic/lsu_data_align.sv ====
//////////////////////////////////////////////////
// Byte lane steering for stores and loads.
// Misaligned accesses are flagged, never split
//////////////////////////////////////////////////

`default_nettype none

module lsu_data_align import lsu_pmp_pkg::*; (
  input  mem_type_e         type_i,
  input  logic [1:0]        offset_i,
  input  logic              sign_ext_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [DATA_W-1:0] rdata_i,
  output logic [BE_W-1:0]   be_o,
  output logic [DATA_W-1:0] wdata_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              misaligned_o
);

  logic [DATA_W-1:0] rdata_shift;
  logic [4:0]        lane_shift;

  assign lane_shift = {offset_i, 3'b000};

  // Store data moves up into the addressed lanes
  assign wdata_o = wdata_i << lane_shift;

  // Load data comes down to lane 0 before extension
  assign rdata_shift = rdata_i >> lane_shift;

  always_comb begin
    unique case (type_i)
      MEM_HALF: begin
        be_o         = 4'b0011 << offset_i;
        misaligned_o = offset_i[0];
        rdata_o      = {{16{sign_ext_i & rdata_shift[15]}}, rdata_shift[15:0]};
      end
      MEM_BYTE: begin
        be_o         = 4'b0001 << offset_i;
        misaligned_o = 1'b0;
        rdata_o      = {{24{sign_ext_i & rdata_shift[7]}}, rdata_shift[7:0]};
      end
      // Word, also taken for the unused encoding
      default: begin
        be_o         = 4'b1111;
        misaligned_o = |offset_i;
        rdata_o      = rdata_shift;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/pmp_checker.sv ====
//////////////////////////////////////////////////
// Data side PMP decision, purely combinational.
// TOR and NA4 only, lowest matching entry wins
//////////////////////////////////////////////////

`default_nettype none

module pmp_checker import lsu_pmp_pkg::*; (
  input  pmp_entry_t        entries_i [NUM_REGIONS],
  input  priv_lvl_e         priv_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              we_i,
  output logic              allow_o
);

  logic [PMP_AW-1:0]      word_addr;
  logic [NUM_REGIONS-1:0] match;
  logic                   any_match;
  pmp_cfg_t               hit_cfg;
  logic                   hit_perm;

  assign word_addr = addr_i[ADDR_W-1:2];

  //////////////////////////////////////////////////
  // Per entry matching
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_region
    logic [PMP_AW-1:0] base;
    logic              tor_hit;
    logic              na4_hit;

    // TOR range starts at the previous entry, zero for the first one
    if (i == 0) begin : g_first
      assign base = '0;
    end else begin : g_rest
      assign base = entries_i[i-1].addr;
    end

    assign tor_hit = (base <= word_addr) && (word_addr < entries_i[i].addr);
    assign na4_hit = (word_addr == entries_i[i].addr);

    assign match[i] = (entries_i[i].cfg.mode == PMP_TOR) ? tor_hit :
                      (entries_i[i].cfg.mode == PMP_NA4) ? na4_hit : 1'b0;
  end

  //////////////////////////////////////////////////
  // Priority and permission
  //////////////////////////////////////////////////

  // Walk downwards so the lowest index is taken last
  always_comb begin
    any_match = 1'b0;
    hit_cfg   = '0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (match[i]) begin
        any_match = 1'b1;
        hit_cfg   = entries_i[i].cfg;
      end
    end
  end

  assign hit_perm = we_i ? hit_cfg.w : hit_cfg.r;

  // M mode is only restricted by locked entries
  always_comb begin
    if (priv_i == PRIV_M) begin
      allow_o = ~(any_match & hit_cfg.lock & ~hit_perm);
    end else begin
      allow_o = any_match & hit_perm;
    end
  end

endmodule

`default_nettype wire

// ==== logic/pmp_cfg_regs.sv ====
//////////////////////////////////////////////////
// Wishbone classic slave for the privilege mode and
// PMP entries. Ack one cycle after cyc/stb; write
// only while the unit is idle
//////////////////////////////////////////////////

`default_nettype none

module pmp_cfg_regs import lsu_pmp_pkg::*; (
  input  logic              clk,
  input  logic              rst_ni,
  input  wb_req_t           wb_i,
  output logic              wb_ack_o,
  output logic [DATA_W-1:0] wb_dat_o,
  output pmp_entry_t        entries_o [NUM_REGIONS],
  output priv_lvl_e         priv_o
);

  pmp_entry_t        entries_q [NUM_REGIONS];
  priv_lvl_e         priv_q;
  logic              ack_q;
  logic              access;
  logic              wr_en;
  logic [DATA_W-1:0] rdata_d;
  logic [DATA_W-1:0] rdata_q;

  // One access per strobe, the ack cycle is ignored
  assign access = wb_i.cyc & wb_i.stb & ~ack_q;
  assign wr_en  = access & wb_i.we;

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    if (wb_i.adr == WB_AW'(REG_PRIV)) begin
      rdata_d[0] = priv_q;
    end
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (wb_i.adr == WB_AW'(REG_CFG_BASE + i)) begin
        rdata_d[$bits(pmp_cfg_t)-1:0] = entries_q[i].cfg;
      end
      if (wb_i.adr == WB_AW'(REG_ADDR_BASE + i)) begin
        rdata_d[PMP_AW-1:0] = entries_q[i].addr;
      end
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      priv_q <= PRIV_M;
      for (int i = 0; i < NUM_REGIONS; i++) begin
        entries_q[i] <= '0;
      end
    end else if (wr_en) begin
      if (wb_i.adr == WB_AW'(REG_PRIV)) begin
        priv_q <= priv_lvl_e'(wb_i.dat[0]);
      end
      for (int i = 0; i < NUM_REGIONS; i++) begin
        // Lock holds both words until reset
        if (!entries_q[i].cfg.lock) begin
          if (wb_i.adr == WB_AW'(REG_CFG_BASE + i)) begin
            entries_q[i].cfg <= pmp_cfg_t'(wb_i.dat[$bits(pmp_cfg_t)-1:0]);
          end
          if (wb_i.adr == WB_AW'(REG_ADDR_BASE + i)) begin
            entries_q[i].addr <= wb_i.dat[PMP_AW-1:0];
          end
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_ack_o  = ack_q;
  assign wb_dat_o  = rdata_q;
  assign entries_o = entries_q;
  assign priv_o    = priv_q;

  // Host keeps the strobe up until it has seen the ack
  ack_needs_stb_a: assert property (@(posedge clk) disable iff (!rst_ni)
    wb_ack_o |-> (wb_i.cyc && wb_i.stb));

endmodule

`default_nettype wire

// ==== logic/lsu_pmp_pkg.sv ====
//////////////////////////////////////////////////
// Shared widths, encodings and bus structs for the
// load/store unit. Only OFF, TOR and NA4 matching;
// mode value 3 never matches
//////////////////////////////////////////////////

`default_nettype none

package lsu_pmp_pkg;

  // Sizes
  localparam int NUM_REGIONS = 4;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned BE_W = 4;
  localparam int unsigned PMP_AW = ADDR_W - 2;
  localparam int unsigned WB_AW = 5;

  // Register map, in words
  localparam int unsigned REG_PRIV = 0;
  localparam int unsigned REG_CFG_BASE = 1;
  localparam int unsigned REG_ADDR_BASE = REG_CFG_BASE + NUM_REGIONS;

  typedef enum logic {
    PRIV_U = 1'b0,
    PRIV_M = 1'b1
  } priv_lvl_e;

  // Same codes as the RISC-V pmpcfg A field
  typedef enum logic [1:0] {
    PMP_OFF = 2'b00,
    PMP_TOR = 2'b01,
    PMP_NA4 = 2'b10
  } pmp_mode_e;

  typedef enum logic [1:0] {
    MEM_WORD = 2'b00,
    MEM_HALF = 2'b01,
    MEM_BYTE = 2'b10
  } mem_type_e;

  typedef enum logic [1:0] {
    ERR_NONE       = 2'b00,
    ERR_MISALIGNED = 2'b01,
    ERR_PMP        = 2'b10,
    ERR_BUS        = 2'b11
  } lsu_err_e;

  //////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////

  // Bit 0 is the read permit
  typedef struct packed {
    logic      lock;
    pmp_mode_e mode;
    logic      w;
    logic      r;
  } pmp_cfg_t;

  typedef struct packed {
    pmp_cfg_t          cfg;
    logic [PMP_AW-1:0] addr;
  } pmp_entry_t;

  typedef struct packed {
    logic              we;
    mem_type_e         mtype;
    logic              sign_ext;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } lsu_cmd_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    lsu_err_e          err;
  } lsu_rsp_t;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [WB_AW-1:0]  adr;
    logic [DATA_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire
